/* source/fpa_pkg.sv */
// Shared widths, field types and IEEE-754 constants for the single-precision adder
`default_nettype none

package fpa_pkg;

	// ==============================
	// Field widths
	// ==============================
	localparam int EXP_W  = 8;               // Biased exponent
	localparam int FRAC_W = 23;              // Stored fraction
	localparam int MAN_W  = FRAC_W + 1;      // Fraction plus hidden bit
	localparam int GRS_W  = 3;               // Guard, round, sticky

	// Carry bit on top, GRS below the mantissa
	localparam int WMAN_W = MAN_W + GRS_W + 1;

	// Two extra bits so overflow and underflow show up as range tests
	localparam int SEXP_W = EXP_W + 2;

	// ==============================
	// Field types
	// ==============================
	typedef logic [EXP_W+FRAC_W:0] fp32_t;      // {sign, exp, frac}
	typedef logic [EXP_W-1:0]      exp_t;
	typedef logic [FRAC_W-1:0]     frac_t;
	typedef logic [MAN_W-1:0]      man_t;       // {hidden, frac}
	typedef logic [WMAN_W-1:0]     wman_t;      // {carry, man, g, r, s}
	typedef logic signed [SEXP_W-1:0] sexp_t;

	// ==============================
	// Constants
	// ==============================
	// All-ones exponent marks Inf and NaN
	localparam exp_t EXP_MAX = '1;

	// Beyond this the smaller mantissa only contributes sticky
	localparam int ALIGN_CAP = MAN_W + 3;

	// Quiet NaN returned for every invalid case
	localparam fp32_t CANON_QNAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

/* source/fpa_classify.sv */
// Operand unpack and classification with hidden bit, subnormals flushed to zero
`timescale 1ns/1ps
`default_nettype none

module fpa_classify
	import fpa_pkg::*;
(
	input  fp32_t i_op,

	output logic  o_sign,
	output exp_t  o_exp,
	output man_t  o_man,
	output logic  o_is_zero,
	output logic  o_is_inf,
	output logic  o_is_nan
);

	exp_t  exp_raw;     // Exponent as stored
	frac_t frac_raw;    // Fraction as stored
	logic  exp_zero;
	logic  exp_ones;
	logic  frac_zero;

	// ==============================
	// Field split
	// ==============================
	assign {o_sign, exp_raw, frac_raw} = i_op;

	assign exp_zero  = ~|exp_raw;
	assign exp_ones  = &exp_raw;   // Same as exp_raw == EXP_MAX
	assign frac_zero = ~|frac_raw;

	// ==============================
	// Class detection
	// ==============================
	// Zero exponent covers true zeros and flushed subnormals
	assign o_is_zero = exp_zero;
	assign o_is_inf  = exp_ones & frac_zero;
	assign o_is_nan  = exp_ones & ~frac_zero;

	// Flushed operand carries no magnitude into the datapath
	assign o_exp = exp_zero ? '0 : exp_raw;

	// Hidden bit set for everything else
	// Inf and NaN values get overridden downstream anyway
	assign o_man = exp_zero ? '0 : {1'b1, frac_raw};

endmodule

`default_nettype wire

/* source/fpa_align.sv */
// Magnitude ordering and alignment of the smaller mantissa with guard, round and sticky
`timescale 1ns/1ps
`default_nettype none

module fpa_align
	import fpa_pkg::*;
(
	input  logic  i_sign_a,
	input  logic  i_sign_b,
	input  exp_t  i_exp_a,
	input  exp_t  i_exp_b,
	input  man_t  i_man_a,
	input  man_t  i_man_b,

	output logic  o_sign_big,
	output exp_t  o_exp_big,
	output logic  o_eff_sub,
	output wman_t o_man_big,
	output wman_t o_man_small
);

	localparam int SH_W = MAN_W + ALIGN_CAP;   // Shifter width

	logic            a_ge_b;      // |A| >= |B|
	exp_t            exp_small;
	man_t            man_big;
	man_t            man_small;
	exp_t            exp_diff;
	logic [4:0]      shamt;       // Capped shift, fits 0..27
	logic [SH_W-1:0] shifted;
	logic            sticky;

	// ==============================
	// Operand ordering
	// ==============================
	// Exponent first, mantissa breaks ties
	assign a_ge_b = {i_exp_a, i_man_a} >= {i_exp_b, i_man_b};

	assign o_sign_big = a_ge_b ? i_sign_a : i_sign_b;   // Sign of larger magnitude
	assign o_exp_big  = a_ge_b ? i_exp_a  : i_exp_b;
	assign exp_small  = a_ge_b ? i_exp_b  : i_exp_a;
	assign man_big    = a_ge_b ? i_man_a  : i_man_b;
	assign man_small  = a_ge_b ? i_man_b  : i_man_a;

	assign o_eff_sub = i_sign_a ^ i_sign_b;

	// ==============================
	// Alignment shift
	// ==============================
	assign exp_diff = o_exp_big - exp_small;   // Never negative after ordering
	assign shamt    = (exp_diff > ALIGN_CAP) ? 5'(ALIGN_CAP) : exp_diff[4:0];

	// Zero pad below so shifted-out bits are kept for sticky
	assign shifted = {man_small, {ALIGN_CAP{1'b0}}} >> shamt;

	// Everything under guard and round collapses into one bit
	assign sticky = |shifted[ALIGN_CAP-3:0];

	assign o_man_big   = {1'b0, man_big, {GRS_W{1'b0}}};
	assign o_man_small = {1'b0, shifted[SH_W-1 -: MAN_W+2], sticky};

	// Subtraction downstream relies on this ordering
	a_big_ge_small: assert final ($isunknown({o_man_big, o_man_small}) ||
		(o_man_big >= o_man_small));

endmodule

`default_nettype wire

/* source/fpa_normalize.sv */
// Mantissa add or subtract followed by carry shift or leading-zero normalization
`timescale 1ns/1ps
`default_nettype none

module fpa_normalize
	import fpa_pkg::*;
(
	input  logic  i_eff_sub,
	input  exp_t  i_exp_big,
	input  wman_t i_man_big,
	input  wman_t i_man_small,

	output sexp_t o_exp,
	output wman_t o_man,
	output logic  o_cancel
);

	wman_t      sum;
	logic       carry;     // Sum reached 2.0 or more
	logic [4:0] lz;        // Leading zeros below the carry bit
	logic       found;
	sexp_t      exp_ext;

	// ==============================
	// Mantissa add / sub
	// ==============================
	// Big >= small so the difference stays positive
	assign sum = i_eff_sub ? (i_man_big - i_man_small) : (i_man_big + i_man_small);

	assign carry    = sum[WMAN_W-1];
	assign o_cancel = (sum == '0);   // Exact cancellation

	// ==============================
	// Leading zero count
	// ==============================
	always_comb begin
		lz    = '0;
		found = 1'b0;
		// Scan from just under the carry bit downwards
		for (int i = WMAN_W - 2; i >= 0; i--) begin
			if (!found) begin
				if (sum[i]) begin
					found = 1'b1;
				end else begin
					lz = lz + 5'd1;
				end
			end
		end
	end

	// ==============================
	// Normalize
	// ==============================
	assign exp_ext = sexp_t'(i_exp_big);   // Zero extended, stays positive

	always_comb begin
		if (carry) begin
			// Right by one, dropped bit folds into sticky
			o_man = {1'b0, sum[WMAN_W-1:2], sum[1] | sum[0]};
			o_exp = exp_ext + sexp_t'(1);
		end else begin
			o_man = sum << lz;                 // Leading one lands at bit 26
			o_exp = exp_ext - sexp_t'(lz);     // May go below 1, round flushes it
		end
	end

	// Round assumes a normalized mantissa unless the sum vanished
	a_norm_lead_one: assert final ($isunknown({o_man, o_cancel}) ||
		o_cancel || o_man[WMAN_W-2]);

endmodule

`default_nettype wire

/* source/fpa_round.sv */
// Round to nearest-even with overflow to infinity, tiny flush and result packing
`timescale 1ns/1ps
`default_nettype none

module fpa_round
	import fpa_pkg::*;
(
	input  logic  i_sign,
	input  sexp_t i_exp,
	input  wman_t i_man,
	input  logic  i_cancel,

	output fp32_t o_result
);

	logic           lsb, guard, rnd, sticky;
	logic           inc;          // Round up
	logic [MAN_W:0] rounded;      // Extra top bit catches round carry
	sexp_t          exp_r;
	frac_t          frac_r;

	// ==============================
	// Nearest-even decision
	// ==============================
	assign lsb    = i_man[GRS_W];
	assign guard  = i_man[2];
	assign rnd    = i_man[1];
	assign sticky = i_man[0];

	// Above half, or exactly half with odd LSB
	assign inc = guard & (rnd | sticky | lsb);

	assign rounded = {1'b0, i_man[WMAN_W-2 -: MAN_W]} + (MAN_W+1)'(inc);

	// Round carry means mantissa is 10.000..., renormalize by one
	assign exp_r  = i_exp + sexp_t'(rounded[MAN_W]);
	assign frac_r = rounded[MAN_W] ? rounded[MAN_W-1:1] : rounded[FRAC_W-1:0];

	// ==============================
	// Range checks and pack
	// ==============================
	always_comb begin
		if (i_cancel) begin
			o_result = '0;                                   // x - x is +0
		end else if (exp_r >= sexp_t'(EXP_MAX)) begin
			o_result = {i_sign, EXP_MAX, {FRAC_W{1'b0}}};    // Overflow to Inf
		end else if (exp_r < sexp_t'(1)) begin
			o_result = {i_sign, {(EXP_W+FRAC_W){1'b0}}};     // Tiny, signed zero
		end else begin
			o_result = {i_sign, exp_r[EXP_W-1:0], frac_r};
		end
	end

endmodule

`default_nettype wire

/* source/fpa_special.sv */
// Special-case override for NaN, infinity and zero operands
`timescale 1ns/1ps
`default_nettype none

module fpa_special
	import fpa_pkg::*;
(
	input  fp32_t i_op_a,
	input  fp32_t i_op_b,
	input  logic  i_a_zero,
	input  logic  i_a_inf,
	input  logic  i_a_nan,
	input  logic  i_b_zero,
	input  logic  i_b_inf,
	input  logic  i_b_nan,
	input  fp32_t i_normal,

	output fp32_t o_result
);

	logic sign_a, sign_b;

	assign sign_a = i_op_a[EXP_W+FRAC_W];
	assign sign_b = i_op_b[EXP_W+FRAC_W];

	// ==============================
	// Priority select
	// ==============================
	always_comb begin
		o_result = i_normal;   // Regular datapath result by default
		if (i_a_nan || i_b_nan || (i_a_inf && i_b_inf && (sign_a ^ sign_b))) begin
			// Any NaN, or Inf - Inf
			o_result = CANON_QNAN;
		end else if (i_a_inf) begin
			o_result = {sign_a, EXP_MAX, {FRAC_W{1'b0}}};
		end else if (i_b_inf) begin
			o_result = {sign_b, EXP_MAX, {FRAC_W{1'b0}}};
		end else if (i_a_zero && i_b_zero) begin
			// -0 only when both are negative
			o_result = {sign_a & sign_b, {(EXP_W+FRAC_W){1'b0}}};
		end else if (i_a_zero) begin
			o_result = i_op_b;
		end else if (i_b_zero) begin
			o_result = i_op_a;
		end
	end

	// NaN must never leak its payload
	a_nan_canon: assert final ($isunknown({i_a_nan, i_b_nan, o_result}) ||
		!(i_a_nan || i_b_nan) || (o_result == CANON_QNAN));

endmodule

`default_nettype wire

/* source/fpa_adder.sv */
// Two-stage single-precision adder top with input and output registers
`timescale 1ns/1ps
`default_nettype none

module fpa_adder
	import fpa_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_arst_n,
	input  logic  i_valid,
	input  fp32_t i_op_a,
	input  fp32_t i_op_b,

	output logic  o_valid,
	output fp32_t o_result
);

	logic  valid_s1;
	fp32_t op_a_s1, op_b_s1;           // Captured operands
	logic  sign_a, sign_b;
	exp_t  exp_a, exp_b;
	man_t  man_a, man_b;
	logic  a_zero, a_inf, a_nan;
	logic  b_zero, b_inf, b_nan;
	logic  sign_big, eff_sub;
	exp_t  exp_big;
	wman_t man_big, man_small;
	sexp_t norm_exp;
	wman_t norm_man;
	logic  cancel;
	fp32_t normal_result, final_result;

	// ==============================
	// Stage 1 input register
	// ==============================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_s1 <= 1'b0;
		end else begin
			valid_s1 <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			op_a_s1 <= i_op_a;
			op_b_s1 <= i_op_b;
		end
	end

	// ==============================
	// Combinational datapath
	// ==============================
	fpa_classify u_classify_a (
		.i_op (op_a_s1), .o_sign (sign_a), .o_exp (exp_a), .o_man (man_a),
		.o_is_zero (a_zero), .o_is_inf (a_inf), .o_is_nan (a_nan)
	);

	fpa_classify u_classify_b (
		.i_op (op_b_s1), .o_sign (sign_b), .o_exp (exp_b), .o_man (man_b),
		.o_is_zero (b_zero), .o_is_inf (b_inf), .o_is_nan (b_nan)
	);

	fpa_align u_align (
		.i_sign_a (sign_a), .i_sign_b (sign_b),
		.i_exp_a (exp_a), .i_exp_b (exp_b),
		.i_man_a (man_a), .i_man_b (man_b),
		.o_sign_big (sign_big), .o_exp_big (exp_big), .o_eff_sub (eff_sub),
		.o_man_big (man_big), .o_man_small (man_small)
	);

	fpa_normalize u_normalize (
		.i_eff_sub (eff_sub), .i_exp_big (exp_big),
		.i_man_big (man_big), .i_man_small (man_small),
		.o_exp (norm_exp), .o_man (norm_man), .o_cancel (cancel)
	);

	fpa_round u_round (
		.i_sign (sign_big), .i_exp (norm_exp), .i_man (norm_man),
		.i_cancel (cancel), .o_result (normal_result)
	);

	fpa_special u_special (
		.i_op_a (op_a_s1), .i_op_b (op_b_s1),
		.i_a_zero (a_zero), .i_a_inf (a_inf), .i_a_nan (a_nan),
		.i_b_zero (b_zero), .i_b_inf (b_inf), .i_b_nan (b_nan),
		.i_normal (normal_result), .o_result (final_result)
	);

	// ==============================
	// Stage 2 output register
	// ==============================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid  <= 1'b0;
			o_result <= '0;
		end else begin
			o_valid <= valid_s1;
			if (valid_s1) o_result <= final_result;   // Hold between results
		end
	end

	// Fixed two-cycle latency, no stalls
	property p_valid_latency;
		logic v;
		(1'b1, v = i_valid) |=> ##1 (o_valid == v);
	endproperty

	a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		p_valid_latency);

endmodule

`default_nettype wire

/* verification/tb_fpa_adder.sv */
// Directed testbench for the two-stage single-precision adder with a real-valued model
`timescale 1ns/1ps
`default_nettype none

module tb_fpa_adder;

	localparam int TIMEOUT_CYCLES = 20;   // Generous against a 2-cycle latency
	localparam int BURST_LEN      = 8;

	logic        clk;
	logic        arst_n;
	logic        valid_in;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic        valid_out;
	logic [31:0] result;
	integer      seed = 38;

	fpa_adder i_fpa_adder (
		.i_clk (clk), .i_arst_n (arst_n), .i_valid (valid_in),
		.i_op_a (op_a), .i_op_b (op_b),
		.o_valid (valid_out), .o_result (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	// ==============================
	// Reference model
	// ==============================
	// Normal single to double, exponent rebiased by 1023 - 127
	function automatic real to_real(input logic [31:0] f);
		logic [10:0] e;
		e = {3'b000, f[30:23]} + 11'd896;
		return $bitstoreal({f[31], e, f[22:0], 29'h0});
	endfunction

	// Double to single with nearest-even, overflow to Inf, tiny flushed
	function automatic logic [31:0] double_to_single(input real r);
		logic [63:0] d;
		logic [52:0] m;
		logic [24:0] keep;
		logic        inc;
		int          e;
		d    = $realtobits(r);
		m    = {1'b1, d[51:0]};
		e    = d[62:52];
		e    = e - 896;
		inc  = m[28] & ((|m[27:0]) | m[29]);   // Above half, or tie with odd LSB
		keep = {1'b0, m[52:29]} + 25'(inc);
		if (keep[24]) begin
			e    = e + 1;
			keep = keep >> 1;
		end
		if (e >= 255) return {d[63], 8'hFF, 23'h0};
		if (e < 1) return {d[63], 31'h0};    // Sign of the exact sum
		return {d[63], e[7:0], keep[22:0]};
	endfunction

	function automatic logic [31:0] expected_sum(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] fa, fb;
		logic        a_nan, a_inf, a_zero;
		logic        b_nan, b_inf, b_zero;
		real         rs;
		fa     = (a[30:23] == 8'h00) ? {a[31], 31'h0} : a;   // Subnormals read as zero
		fb     = (b[30:23] == 8'h00) ? {b[31], 31'h0} : b;
		a_nan  = (fa[30:23] == 8'hFF) && (fa[22:0] != 0);
		b_nan  = (fb[30:23] == 8'hFF) && (fb[22:0] != 0);
		a_inf  = (fa[30:23] == 8'hFF) && (fa[22:0] == 0);
		b_inf  = (fb[30:23] == 8'hFF) && (fb[22:0] == 0);
		a_zero = (fa[30:0] == 0);
		b_zero = (fb[30:0] == 0);
		if (a_nan || b_nan || (a_inf && b_inf && (fa[31] != fb[31]))) return 32'h7FC0_0000;
		if (a_inf) return fa;
		if (b_inf) return fb;
		if (a_zero && b_zero) return {fa[31] & fb[31], 31'h0};
		if (a_zero) return fb;
		if (b_zero) return fa;
		rs = to_real(fa) + to_real(fb);
		if (rs == 0.0) return 32'h0;   // Exact cancellation
		return double_to_single(rs);
	endfunction

	// Normal value in a narrow exponent window so operands interact
	function automatic logic [31:0] random_normal(input logic sign);
		logic [7:0]  e;
		logic [22:0] f;
		e = 8'd110 + 8'($unsigned($random(seed)) % 32);
		f = 23'($random(seed));
		return {sign, e, f};
	endfunction

	// ==============================
	// Drive and check helpers
	// ==============================
	task automatic report_failure();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] %s got %h expected %h", name, got, expected);
			report_failure();
		end
	endtask

	task automatic add_and_check(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] expected);
		int waited;
		@(negedge clk);
		op_a     = a;
		op_b     = b;
		valid_in = 1'b1;
		@(negedge clk);
		valid_in = 1'b0;   // Single-cycle strobe
		waited   = 0;
		while (!valid_out) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				$display("Timed out waiting for o_valid");
				report_failure();
			end
		end
		check_value("o_result", result, expected);
	endtask

	// ==============================
	// Directed tests
	// ==============================
	task automatic check_reset();
		@(posedge clk);   // First rising edge under reset
		repeat (4) begin
			@(negedge clk);
			check_value("o_valid", {31'h0, valid_out}, 32'h0);
			check_value("o_result", result, 32'h0);
			valid_in = 1'b1;   // Strobe high, only reset keeps the stages empty
		end
		arst_n   = 1'b1;
		valid_in = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_value("o_valid", {31'h0, valid_out}, 32'h0);   // Nothing captured under reset
		end
	endtask

	task automatic test_same_sign();
		logic [31:0] a, b;
		logic        s;
		add_and_check(32'h3F80_0000, 32'h4000_0000, 32'h4040_0000);   // 1 + 2 = 3
		add_and_check(32'hBF80_0000, 32'hC000_0000, 32'hC040_0000);
		for (int i = 0; i < 40; i++) begin
			s = 1'($random(seed));
			a = random_normal(s);
			b = random_normal(s);
			add_and_check(a, b, expected_sum(a, b));
		end
	endtask

	task automatic test_opposite_sign();
		logic [31:0] a, b;
		logic        s;
		add_and_check(32'h3FC0_0000, 32'hBFC0_0000, 32'h0000_0000);   // x - x is +0
		add_and_check(32'h3F80_0001, 32'hBF80_0000, 32'h3400_0000);   // Long left shift
		add_and_check(32'h60AD_78EC, 32'hBF80_0000, expected_sum(32'h60AD_78EC, 32'hBF80_0000));
		for (int i = 0; i < 20; i++) begin
			s = 1'($random(seed));
			a = random_normal(s);
			b = random_normal(~s);
			add_and_check(a, b, expected_sum(a, b));
		end
	endtask

	task automatic test_rounding();
		add_and_check(32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000);   // Tie, even stays
		add_and_check(32'h3F80_0000, 32'h3440_0000, 32'h3F80_0002);   // Tie, odd goes up
		add_and_check(32'h60AD_78EC, 32'h3F80_0000, 32'h60AD_78EC);   // Small one lost
		add_and_check(32'h3F80_0000, 32'h7000_0000, 32'h7000_0000);
	endtask

	task automatic test_specials();
		add_and_check(32'h7F80_0001, 32'h3F80_0000, 32'h7FC0_0000);   // Signalling NaN
		add_and_check(32'h3F80_0000, 32'hFFC1_2345, 32'h7FC0_0000);
		add_and_check(32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000);   // Inf - Inf
		add_and_check(32'h7F80_0000, 32'h3F80_0000, 32'h7F80_0000);
		add_and_check(32'h40A0_0000, 32'hFF80_0000, 32'hFF80_0000);
		add_and_check(32'h0000_0000, 32'h8000_0000, 32'h0000_0000);   // +0 + -0
		add_and_check(32'h8000_0000, 32'h8000_0000, 32'h8000_0000);
		add_and_check(32'h0000_0000, 32'h3FC0_0000, 32'h3FC0_0000);
		add_and_check(32'hC000_0000, 32'h8000_0000, 32'hC000_0000);
	endtask

	task automatic test_overflow_flush();
		add_and_check(32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000);
		add_and_check(32'hFF7F_FFFF, 32'hFF00_0000, 32'hFF80_0000);
		add_and_check(32'h0000_0001, 32'h3F80_0000, 32'h3F80_0000);   // Subnormal as zero
		add_and_check(32'h0040_0000, 32'h8040_0000, 32'h0000_0000);
		add_and_check(32'h8000_0005, 32'h8000_0003, 32'h8000_0000);
		add_and_check(32'h0080_0001, 32'h8080_0000, 32'h0000_0000);   // Tiny, flushed
		add_and_check(32'h0080_0000, 32'h8080_0001, 32'h8000_0000);
	endtask

	// Latency is fixed at 2, so outputs are checked cycle by cycle
	task automatic test_back_to_back();
		logic [31:0] a_arr [BURST_LEN];
		logic [31:0] b_arr [BURST_LEN];
		logic [31:0] exp_arr [BURST_LEN];
		for (int i = 0; i < BURST_LEN; i++) begin
			a_arr[i]   = random_normal(1'($random(seed)));
			b_arr[i]   = random_normal(1'($random(seed)));
			exp_arr[i] = expected_sum(a_arr[i], b_arr[i]);
		end
		for (int c = 0; c < BURST_LEN + 3; c++) begin
			@(negedge clk);
			if (c >= 2 && c < BURST_LEN + 2) begin
				check_value("o_valid", {31'h0, valid_out}, 32'h1);
				check_value("o_result", result, exp_arr[c-2]);
			end else begin
				check_value("o_valid", {31'h0, valid_out}, 32'h0);
			end
			if (c < BURST_LEN) begin
				op_a     = a_arr[c];
				op_b     = b_arr[c];
				valid_in = 1'b1;
			end else begin
				valid_in = 1'b0;
			end
		end
		check_value("o_result", result, exp_arr[BURST_LEN-1]);   // Held with o_valid low
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		arst_n   = 1'b0;
		valid_in = 1'b0;
		op_a     = '0;
		op_b     = '0;
		check_reset();
		test_same_sign();
		test_opposite_sign();
		test_rounding();
		test_specials();
		test_overflow_flush();
		test_back_to_back();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
source/fpa_pkg.sv
source/fpa_classify.sv
source/fpa_align.sv
source/fpa_normalize.sv
source/fpa_round.sv
source/fpa_special.sv
source/fpa_adder.sv
verification/tb_fpa_adder.sv

/* Bender.yml */
package:
  name: fpa_adder

sources:
  - files:
      - source/fpa_pkg.sv
      - source/fpa_classify.sv
      - source/fpa_align.sv
      - source/fpa_normalize.sv
      - source/fpa_round.sv
      - source/fpa_special.sv
      - source/fpa_adder.sv
  - target: test
    files:
      - verification/tb_fpa_adder.sv
